//--- flist.f
src/csr_pkg.sv
src/csr_access.sv
src/priv_fsm.sv
src/trap_regs.sv
src/perf_counters.sv
src/csr_top.sv
verif/csr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the csr testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module csr_tb \
  --Mdir obj_dir -o csr_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

out=$(./obj_dir/csr_tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
  exit 0
fi
exit 1

//--- src/csr_access.sv
// csr access unit
// decodes the address, builds the read word, applies the set/clear/write
// operation and raises one write strobe for the addressed register
module csr_access (
  input  logic                                          csr_access_i,
  input  csr_pkg::csr_addr_t                            csr_addr_i,
  input  csr_pkg::csr_op_e                              csr_op_i,
  input  logic [csr_pkg::xlen-1:0]                      csr_wdata_i,
  input  logic [3:0]                                    core_id_i,
  input  logic [5:0]                                    cluster_id_i,
  input  logic                                          mie_i,
  input  logic                                          mpie_i,
  input  csr_pkg::priv_lvl_e                            mpp_i,
  input  csr_pkg::priv_lvl_e                            priv_lvl_o_i,
  input  logic [csr_pkg::tvec_w-1:0]                    mtvec_i,
  input  logic [csr_pkg::xlen-1:0]                      mepc_i,
  input  logic [csr_pkg::cause_w-1:0]                   mcause_i,
  input  logic [csr_pkg::n_perf_cnt-1:0]                pcer_i,
  input  logic [1:0]                                    pcmr_i,
  input  logic [csr_pkg::n_perf_cnt-1:0][csr_pkg::xlen-1:0] pccr_i,
  output logic [csr_pkg::xlen-1:0]                      csr_rdata_o,
  output logic [csr_pkg::xlen-1:0]                      wdata_int_o,
  output logic                                          mstatus_we_o,
  output logic                                          mtvec_we_o,
  output logic                                          mepc_we_o,
  output logic                                          mcause_we_o,
  output logic                                          pcer_we_o,
  output logic                                          pcmr_we_o,
  output logic [csr_pkg::n_perf_cnt-1:0]                pccr_we_o
);
  import csr_pkg::*;

  logic [xlen-1:0] rdata_int;
  logic            we_int;
  // single counter window 0x780..0x787
  logic            cnt_sel;
  logic [2:0]      cnt_idx;

  assign cnt_sel = (csr_addr_i[11:3] == addr_pccr_base[11:3]);
  assign cnt_idx = csr_addr_i[2:0];

  ////////////////////////////////
  // read mux
  ////////////////////////////////

  always_comb begin
    rdata_int = '0;
    case (csr_addr_i)
      addr_mstatus: begin
        rdata_int[mstatus_mpp_lsb +: 2] = mpp_i;
        rdata_int[mstatus_mpie_bit]     = mpie_i;
        rdata_int[mstatus_mie_bit]      = mie_i;
      end
      addr_mtvec:   rdata_int = {mtvec_i, {(xlen - tvec_w){1'b0}}};
      addr_mepc:    rdata_int = mepc_i;
      // flag on top, code in the low bits
      addr_mcause:  rdata_int = {mcause_i[cause_w-1], {(xlen - cause_w){1'b0}},
                                 mcause_i[cause_w-2:0]};
      addr_mhartid: rdata_int = {21'b0, cluster_id_i, 1'b0, core_id_i};
      addr_priv:    rdata_int[1:0] = priv_lvl_o_i;
      addr_pcer:    rdata_int[n_perf_cnt-1:0] = pcer_i;
      addr_pcmr:    rdata_int[1:0] = pcmr_i;
      default: begin
        // write-to-all address falls here and reads zero
        if (cnt_sel) begin
          rdata_int = pccr_i[cnt_idx];
        end
      end
    endcase
  end

  // nothing is driven out while idle
  assign csr_rdata_o = csr_access_i ? rdata_int : '0;

  ////////////////////////////////
  // operation unit
  ////////////////////////////////

  always_comb begin
    case (csr_op_i)
      op_write: wdata_int_o = csr_wdata_i;
      op_set:   wdata_int_o = csr_wdata_i | rdata_int;
      op_clear: wdata_int_o = rdata_int & ~csr_wdata_i;
      default:  wdata_int_o = csr_wdata_i;
    endcase
  end

  assign we_int = csr_access_i && (csr_op_i != op_none);

  // one strobe per register, all counters on the broadcast address
  always_comb begin
    mstatus_we_o = 1'b0;
    mtvec_we_o   = 1'b0;
    mepc_we_o    = 1'b0;
    mcause_we_o  = 1'b0;
    pcer_we_o    = 1'b0;
    pcmr_we_o    = 1'b0;
    pccr_we_o    = '0;
    if (we_int) begin
      case (csr_addr_i)
        addr_mstatus:  mstatus_we_o = 1'b1;
        addr_mtvec:    mtvec_we_o   = 1'b1;
        addr_mepc:     mepc_we_o    = 1'b1;
        addr_mcause:   mcause_we_o  = 1'b1;
        addr_pcer:     pcer_we_o    = 1'b1;
        addr_pcmr:     pcmr_we_o    = 1'b1;
        addr_pccr_all: pccr_we_o    = '1;
        default: begin
          if (cnt_sel) begin
            pccr_we_o[cnt_idx] = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- src/csr_pkg.sv
// machine-mode csr package
// shared types, register map and field positions for the csr block
package csr_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////

  // register data width
  localparam int xlen = 32;
  // number of perf counters, tied to the event list
  localparam int n_perf_cnt = 8;
  // cause width, msb is the interrupt flag
  localparam int cause_w = 6;
  // trap vector base, address bits 31 to 8
  localparam int tvec_w = 24;

  typedef logic [11:0] csr_addr_t;

  // csr access operation
  typedef enum logic [1:0] {
    op_none  = 2'b00,
    op_write = 2'b01,
    op_set   = 2'b10,
    op_clear = 2'b11
  } csr_op_e;

  // privilege levels, only user and machine
  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_m = 2'b11
  } priv_lvl_e;

  ////////////////////////////////
  // register map
  ////////////////////////////////

  localparam csr_addr_t addr_mstatus   = 12'h300;
  localparam csr_addr_t addr_mtvec     = 12'h305;
  localparam csr_addr_t addr_mepc      = 12'h341;
  localparam csr_addr_t addr_mcause    = 12'h342;
  localparam csr_addr_t addr_mhartid   = 12'hF14;
  // current level, not a standard csr
  localparam csr_addr_t addr_priv      = 12'hC10;
  localparam csr_addr_t addr_pcer      = 12'h7A0;
  localparam csr_addr_t addr_pcmr      = 12'h7A1;
  localparam csr_addr_t addr_pccr_base = 12'h780;
  // writes hit every counter
  localparam csr_addr_t addr_pccr_all  = 12'h79F;

  // mstatus field positions
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_lsb  = 11;

endpackage

//--- src/csr_top.sv
// csr block top level
// ties the access unit to the privilege fsm, trap registers and counters
module csr_top #(
  parameter logic [csr_pkg::tvec_w-1:0] mtvec_reset = 24'h1C0000
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [3:0]                   core_id_i,
  input  logic [5:0]                   cluster_id_i,
  input  logic                         csr_access_i,
  input  csr_pkg::csr_addr_t           csr_addr_i,
  input  csr_pkg::csr_op_e             csr_op_i,
  input  logic [csr_pkg::xlen-1:0]     csr_wdata_i,
  input  logic                         csr_save_cause_i,
  input  logic                         csr_save_if_i,
  input  logic                         csr_save_id_i,
  input  logic                         csr_restore_mret_i,
  input  logic [csr_pkg::cause_w-1:0]  csr_cause_i,
  input  logic [csr_pkg::xlen-1:0]     pc_if_i,
  input  logic [csr_pkg::xlen-1:0]     pc_id_i,
  input  logic                         id_valid_i,
  input  logic                         is_decoding_i,
  input  logic                         ld_stall_i,
  input  logic                         jump_i,
  input  logic                         branch_i,
  input  logic                         branch_taken_i,
  input  logic                         mem_load_i,
  input  logic                         mem_store_i,
  output logic [csr_pkg::xlen-1:0]     csr_rdata_o,
  output logic [csr_pkg::tvec_w-1:0]   mtvec_o,
  output logic [csr_pkg::xlen-1:0]     epc_o,
  output csr_pkg::priv_lvl_e           priv_lvl_o,
  output logic                         m_irq_enable_o
);
  import csr_pkg::*;

  // shared write data and strobes
  logic [xlen-1:0]                  wdata_int;
  logic                             mstatus_we;
  logic                             mtvec_we;
  logic                             mepc_we;
  logic                             mcause_we;
  logic                             pcer_we;
  logic                             pcmr_we;
  logic [n_perf_cnt-1:0]            pccr_we;
  // stored values back to the read mux
  logic                             mie;
  logic                             mpie;
  priv_lvl_e                        mpp;
  logic [cause_w-1:0]               mcause;
  logic [n_perf_cnt-1:0]            pcer;
  logic [1:0]                       pcmr;
  logic [n_perf_cnt-1:0][xlen-1:0]  pccr;

  csr_access access_i (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .mie_i        (mie),
    .mpie_i       (mpie),
    .mpp_i        (mpp),
    .priv_lvl_o_i (priv_lvl_o),
    .mtvec_i      (mtvec_o),
    .mepc_i       (epc_o),
    .mcause_i     (mcause),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_i       (pccr),
    .csr_rdata_o  (csr_rdata_o),
    .wdata_int_o  (wdata_int),
    .mstatus_we_o (mstatus_we),
    .mtvec_we_o   (mtvec_we),
    .mepc_we_o    (mepc_we),
    .mcause_we_o  (mcause_we),
    .pcer_we_o    (pcer_we),
    .pcmr_we_o    (pcmr_we),
    .pccr_we_o    (pccr_we)
  );

  priv_fsm priv_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .mstatus_we_i       (mstatus_we),
    .wdata_i            (wdata_int),
    .priv_lvl_o         (priv_lvl_o),
    .mie_o              (mie),
    .mpie_o             (mpie),
    .mpp_o              (mpp),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  trap_regs #(
    .mtvec_reset (mtvec_reset)
  ) trap_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .csr_save_cause_i (csr_save_cause_i),
    .csr_save_if_i    (csr_save_if_i),
    .csr_save_id_i    (csr_save_id_i),
    .pc_if_i          (pc_if_i),
    .pc_id_i          (pc_id_i),
    .csr_cause_i      (csr_cause_i),
    .mtvec_we_i       (mtvec_we),
    .mepc_we_i        (mepc_we),
    .mcause_we_i      (mcause_we),
    .wdata_i          (wdata_int),
    .mtvec_o          (mtvec_o),
    .epc_o            (epc_o),
    .mcause_o         (mcause)
  );

  perf_counters perf_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .pcer_we_i      (pcer_we),
    .pcmr_we_i      (pcmr_we),
    .pccr_we_i      (pccr_we),
    .wdata_i        (wdata_int),
    .pcer_o         (pcer),
    .pcmr_o         (pcmr),
    .pccr_o         (pccr)
  );

endmodule

//--- src/perf_counters.sv
// performance counters
// eight event counters with per-counter enable, global enable and
// optional saturation; increments land one cycle after the event
module perf_counters (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              id_valid_i,
  input  logic                                              is_decoding_i,
  input  logic                                              ld_stall_i,
  input  logic                                              jump_i,
  input  logic                                              branch_i,
  input  logic                                              branch_taken_i,
  input  logic                                              mem_load_i,
  input  logic                                              mem_store_i,
  input  logic                                              pcer_we_i,
  input  logic                                              pcmr_we_i,
  input  logic [csr_pkg::n_perf_cnt-1:0]                    pccr_we_i,
  input  logic [csr_pkg::xlen-1:0]                          wdata_i,
  output logic [csr_pkg::n_perf_cnt-1:0]                    pcer_o,
  output logic [1:0]                                        pcmr_o,
  output logic [csr_pkg::n_perf_cnt-1:0][csr_pkg::xlen-1:0] pccr_o
);
  import csr_pkg::*;

  logic                             id_valid_q;
  logic [n_perf_cnt-1:0]            evt;
  logic [n_perf_cnt-1:0]            inc;
  logic [n_perf_cnt-1:0]            inc_q;
  logic [n_perf_cnt-1:0]            pcer_q;
  // bit 0 global enable, bit 1 saturate
  logic [1:0]                       pcmr_q;
  logic [n_perf_cnt-1:0][xlen-1:0]  cnt_q;
  logic [n_perf_cnt-1:0][xlen-1:0]  cnt_d;

  ////////////////////////////////
  // event sources
  ////////////////////////////////

  // cycles
  assign evt[0] = 1'b1;
  // retired instructions
  assign evt[1] = id_valid_i & is_decoding_i;
  // stall and control flow events qualified by last cycle's id_valid
  assign evt[2] = ld_stall_i & id_valid_q;
  assign evt[3] = jump_i & id_valid_q;
  assign evt[4] = branch_i & id_valid_q;
  assign evt[5] = branch_i & branch_taken_i & id_valid_q;
  assign evt[6] = mem_load_i;
  assign evt[7] = mem_store_i;

  assign inc = evt & pcer_q & {n_perf_cnt{pcmr_q[0]}};

  ////////////////////////////////
  // counter next state
  ////////////////////////////////

  always_comb begin
    for (int i = 0; i < n_perf_cnt; i++) begin
      cnt_d[i] = cnt_q[i];
      // hold at all ones when saturating
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // software write overrides a pending increment
      if (pccr_we_i[i]) begin
        cnt_d[i] = wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= 2'b11;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      cnt_q      <= cnt_d;
      if (pcer_we_i) begin
        pcer_q <= wdata_i[n_perf_cnt-1:0];
      end
      if (pcmr_we_i) begin
        pcmr_q <= wdata_i[1:0];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;
  assign pccr_o = cnt_q;

endmodule

//--- src/priv_fsm.sv
// privilege level fsm
// tracks user/machine level and the mstatus interrupt fields
// across trap entry, mret and software writes
module priv_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      csr_save_cause_i,
  input  logic                      csr_restore_mret_i,
  input  logic                      mstatus_we_i,
  input  logic [csr_pkg::xlen-1:0]  wdata_i,
  output csr_pkg::priv_lvl_e        priv_lvl_o,
  output logic                      mie_o,
  output logic                      mpie_o,
  output csr_pkg::priv_lvl_e        mpp_o,
  output logic                      m_irq_enable_o
);
  import csr_pkg::*;

  priv_lvl_e priv_q;
  priv_lvl_e mpp_q;
  logic      mie_q;
  logic      mpie_q;
  // mpp field from write data, any nonzero means machine
  priv_lvl_e mpp_wr;

  assign mpp_wr = (|wdata_i[mstatus_mpp_lsb +: 2]) ? priv_m : priv_u;

  ////////////////////////////////
  // state and status fields
  ////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_q <= priv_m;
      mpp_q  <= priv_m;
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
    end else if (csr_save_cause_i) begin
      // trap entry, always lands in machine mode
      mpie_q <= mie_q;
      mie_q  <= 1'b0;
      mpp_q  <= priv_q;
      priv_q <= priv_m;
    end else if (csr_restore_mret_i) begin
      // mret
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
      priv_q <= mpp_q;
      mpp_q  <= priv_u;
    end else if (mstatus_we_i) begin
      mie_q  <= wdata_i[mstatus_mie_bit];
      mpie_q <= wdata_i[mstatus_mpie_bit];
      mpp_q  <= mpp_wr;
    end
  end

  assign priv_lvl_o = priv_q;
  assign mie_o      = mie_q;
  assign mpie_o     = mpie_q;
  assign mpp_o      = mpp_q;

  // irqs only taken while in machine mode
  assign m_irq_enable_o = mie_q && (priv_q == priv_m);

endmodule

//--- src/trap_regs.sv
// trap registers
// holds mepc, mcause and mtvec, with the exception pc picked from if or id
module trap_regs #(
  parameter logic [csr_pkg::tvec_w-1:0] mtvec_reset = '0
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         csr_save_cause_i,
  input  logic                         csr_save_if_i,
  input  logic                         csr_save_id_i,
  input  logic [csr_pkg::xlen-1:0]     pc_if_i,
  input  logic [csr_pkg::xlen-1:0]     pc_id_i,
  input  logic [csr_pkg::cause_w-1:0]  csr_cause_i,
  input  logic                         mtvec_we_i,
  input  logic                         mepc_we_i,
  input  logic                         mcause_we_i,
  input  logic [csr_pkg::xlen-1:0]     wdata_i,
  output logic [csr_pkg::tvec_w-1:0]   mtvec_o,
  output logic [csr_pkg::xlen-1:0]     epc_o,
  output logic [csr_pkg::cause_w-1:0]  mcause_o
);
  import csr_pkg::*;

  logic [tvec_w-1:0]  mtvec_q;
  logic [xlen-1:0]    mepc_q;
  logic [cause_w-1:0] mcause_q;
  logic [xlen-1:0]    exc_pc;

  // exception pc source, id stage is the fallback
  always_comb begin
    if (csr_save_if_i) begin
      exc_pc = pc_if_i;
    end else begin
      exc_pc = pc_id_i;
    end
  end

  ////////////////////////////////
  // registers
  ////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_q  <= mtvec_reset;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      if (mtvec_we_i) begin
        mtvec_q <= wdata_i[xlen-1 -: tvec_w];
      end
      // trap beats software writes
      if (csr_save_cause_i) begin
        mepc_q   <= exc_pc;
        mcause_q <= csr_cause_i;
      end else begin
        if (mepc_we_i) begin
          mepc_q <= wdata_i;
        end
        if (mcause_we_i) begin
          mcause_q <= {wdata_i[xlen-1], wdata_i[cause_w-2:0]};
        end
      end
    end
  end

  assign mtvec_o  = mtvec_q;
  assign epc_o    = mepc_q;
  assign mcause_o = mcause_q;

endmodule

//--- verif/csr_tb.sv
// csr block testbench
// directed tests for reset values, register operations, trap entry and
// mret, trap priority over writes, and the performance counters
module csr_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import csr_pkg::*;

  localparam logic [tvec_w-1:0] mtvec_init = 24'h00A5C3;
  localparam int clk_period = 100;
  // whole run is a few hundred cycles, limit leaves ample margin
  localparam int max_cycles = 2000;

  logic                clk;
  logic                rst_n;
  logic [3:0]          core_id_i;
  logic [5:0]          cluster_id_i;
  logic                csr_access_i;
  csr_addr_t           csr_addr_i;
  csr_op_e             csr_op_i;
  logic [xlen-1:0]     csr_wdata_i;
  logic                csr_save_cause_i;
  logic                csr_save_if_i;
  logic                csr_save_id_i;
  logic                csr_restore_mret_i;
  logic [cause_w-1:0]  csr_cause_i;
  logic [xlen-1:0]     pc_if_i;
  logic [xlen-1:0]     pc_id_i;
  logic                id_valid_i;
  logic                is_decoding_i;
  logic                ld_stall_i;
  logic                jump_i;
  logic                branch_i;
  logic                branch_taken_i;
  logic                mem_load_i;
  logic                mem_store_i;
  logic [xlen-1:0]     csr_rdata_o;
  logic [tvec_w-1:0]   mtvec_o;
  logic [xlen-1:0]     epc_o;
  priv_lvl_e           priv_lvl_o;
  logic                m_irq_enable_o;

  logic [31:0]         lcg_state;
  int unsigned         cycle_cnt = 0;

  csr_top #(
    .mtvec_reset (mtvec_init)
  ) dut_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .csr_access_i       (csr_access_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_wdata_i        (csr_wdata_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .id_valid_i         (id_valid_i),
    .is_decoding_i      (is_decoding_i),
    .ld_stall_i         (ld_stall_i),
    .jump_i             (jump_i),
    .branch_i           (branch_i),
    .branch_taken_i     (branch_taken_i),
    .mem_load_i         (mem_load_i),
    .mem_store_i        (mem_store_i),
    .csr_rdata_o        (csr_rdata_o),
    .mtvec_o            (mtvec_o),
    .epc_o              (epc_o),
    .priv_lvl_o         (priv_lvl_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: tests did not finish within %0d cycles", max_cycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // set/clear/write rule
  function automatic logic [xlen-1:0] apply_op(input csr_op_e op,
                                               input logic [xlen-1:0] cur,
                                               input logic [xlen-1:0] data);
    case (op)
      op_write: return data;
      op_set:   return cur | data;
      op_clear: return cur & ~data;
      default:  return cur;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_priv(input string name, input priv_lvl_e got, input priv_lvl_e exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // one write request, idle on the next falling edge
  task automatic csr_write(input csr_addr_t addr, input csr_op_e op,
                           input logic [xlen-1:0] data);
    @(negedge clk);
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = op;
    csr_wdata_i  = data;
    @(negedge clk);
    csr_access_i = 1'b0;
    csr_op_i     = op_none;
  endtask

  // read is combinational, sampled mid low phase
  task automatic csr_read(input csr_addr_t addr, output logic [xlen-1:0] data);
    @(negedge clk);
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = op_none;
    #10;
    data = csr_rdata_o;
  endtask

  task automatic expect_read(input csr_addr_t addr, input logic [xlen-1:0] exp);
    logic [xlen-1:0] rd;
    csr_read(addr, rd);
    check_word($sformatf("csr_rdata_o at 0x%03h", addr), rd, exp);
  endtask

  ////////////////////////////////
  // directed tests
  ////////////////////////////////

  task automatic test_reset_values();
    expect_read(addr_mstatus, 32'h0000_1800);
    expect_read(addr_mtvec, {mtvec_init, 8'h00});
    expect_read(addr_mepc, '0);
    expect_read(addr_mcause, '0);
    expect_read(addr_priv, 32'h3);
    expect_read(addr_pcer, '0);
    expect_read(addr_pcmr, 32'h3);
    for (int i = 0; i < n_perf_cnt; i++) begin
      expect_read(csr_addr_t'(addr_pccr_base + i), '0);
    end
    expect_read(addr_pccr_all, '0);
    // unmapped
    expect_read(12'h123, '0);
    check_priv("priv_lvl_o", priv_lvl_o, priv_m);
    check_bit("m_irq_enable_o", m_irq_enable_o, 1'b0);
    check_word("mtvec_o", {8'h00, mtvec_o}, {8'h00, mtvec_init});
  endtask

  task automatic test_operations();
    csr_addr_t       addrs [3];
    logic [xlen-1:0] masks [3];
    logic [xlen-1:0] model [3];
    csr_op_e         ops [3];
    logic [xlen-1:0] data;
    addrs = '{addr_mepc, addr_mtvec, addr_mcause};
    masks = '{32'hFFFF_FFFF, 32'hFFFF_FF00, 32'h8000_001F};
    model = '{32'h0, {mtvec_init, 8'h00}, 32'h0};
    ops   = '{op_write, op_set, op_clear};
    for (int round = 0; round < 2; round++) begin
      for (int r = 0; r < 3; r++) begin
        for (int o = 0; o < 3; o++) begin
          data     = next_rand();
          model[r] = apply_op(ops[o], model[r], data) & masks[r];
          csr_write(addrs[r], ops[o], data);
          expect_read(addrs[r], model[r]);
        end
      end
    end
    check_word("mtvec_o", {mtvec_o, 8'h00}, model[1]);
    check_word("epc_o", epc_o, model[0]);
    // idle bus reads zero
    @(negedge clk);
    csr_access_i = 1'b0;
    csr_addr_i   = addr_mepc;
    #10;
    check_word("csr_rdata_o idle", csr_rdata_o, '0);
    // cluster 0x2D at bits 10..5, core 9 at bits 3..0
    expect_read(addr_mhartid, 32'h0000_05A9);
  endtask

  task automatic test_trap_return();
    logic [xlen-1:0] pc_if;
    pc_if = next_rand();
    csr_write(addr_mstatus, op_set, 32'h0000_0008);
    check_bit("m_irq_enable_o", m_irq_enable_o, 1'b1);
    @(negedge clk);
    csr_save_cause_i = 1'b1;
    csr_save_if_i    = 1'b1;
    pc_if_i          = pc_if;
    pc_id_i          = ~pc_if;
    csr_cause_i      = 6'h2B;
    @(negedge clk);
    csr_save_cause_i = 1'b0;
    csr_save_if_i    = 1'b0;
    check_word("epc_o", epc_o, pc_if);
    expect_read(addr_mcause, 32'h8000_000B);
    // mpie from mie, mie cleared, mpp machine
    expect_read(addr_mstatus, 32'h0000_1880);
    check_bit("m_irq_enable_o", m_irq_enable_o, 1'b0);
    check_priv("priv_lvl_o", priv_lvl_o, priv_m);
    // mpp to user, then mret
    csr_write(addr_mstatus, op_clear, 32'h0000_1800);
    expect_read(addr_mstatus, 32'h0000_0080);
    @(negedge clk);
    csr_restore_mret_i = 1'b1;
    @(negedge clk);
    csr_restore_mret_i = 1'b0;
    check_priv("priv_lvl_o", priv_lvl_o, priv_u);
    expect_read(addr_mstatus, 32'h0000_0088);
    expect_read(addr_priv, 32'h0);
    check_bit("m_irq_enable_o", m_irq_enable_o, 1'b0);
  endtask

  task automatic test_priority();
    logic [xlen-1:0] pc_id;
    pc_id = next_rand();
    @(negedge clk);
    csr_save_cause_i = 1'b1;
    csr_save_id_i    = 1'b1;
    pc_id_i          = pc_id;
    csr_cause_i      = 6'h05;
    csr_access_i     = 1'b1;
    csr_addr_i       = addr_mepc;
    csr_op_i         = op_write;
    csr_wdata_i      = ~pc_id;
    @(negedge clk);
    csr_save_cause_i = 1'b0;
    csr_save_id_i    = 1'b0;
    csr_access_i     = 1'b0;
    csr_op_i         = op_none;
    check_word("epc_o", epc_o, pc_id);
    check_priv("priv_lvl_o", priv_lvl_o, priv_m);
    expect_read(addr_mcause, 32'h0000_0005);
  endtask

  task automatic test_counters();
    int              n_loads;
    int              n_stores;
    logic [xlen-1:0] c0;
    logic [xlen-1:0] c6;
    n_loads  = 5 + int'(next_rand() % 16);
    n_stores = 5 + int'(next_rand() % 16);
    csr_write(addr_pcer, op_write, 32'h0000_00C1);
    for (int i = 0; i < 24; i++) begin
      @(negedge clk);
      mem_load_i  = (i < n_loads);
      mem_store_i = (i < n_stores);
    end
    @(negedge clk);
    mem_load_i  = 1'b0;
    mem_store_i = 1'b0;
    // increment lands a cycle after the event
    @(negedge clk);
    expect_read(csr_addr_t'(addr_pccr_base + 6), xlen'(n_loads));
    expect_read(csr_addr_t'(addr_pccr_base + 7), xlen'(n_stores));
    csr_read(addr_pccr_base, c0);
    check_bit("pccr0 above loads", c0 > xlen'(n_loads), 1'b1);
    check_bit("pccr0 above stores", c0 > xlen'(n_stores), 1'b1);
    // global enable off
    csr_write(addr_pcmr, op_clear, 32'h1);
    expect_read(addr_pcmr, 32'h2);
    @(negedge clk);
    csr_read(addr_pccr_base, c0);
    csr_read(csr_addr_t'(addr_pccr_base + 6), c6);
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      mem_load_i = 1'b1;
    end
    @(negedge clk);
    mem_load_i = 1'b0;
    repeat (2) @(negedge clk);
    expect_read(addr_pccr_base, c0);
    expect_read(csr_addr_t'(addr_pccr_base + 6), c6);
    // saturation
    csr_write(addr_pcmr, op_write, 32'h3);
    csr_write(addr_pccr_base, op_write, 32'hFFFF_FFFE);
    repeat (3) @(negedge clk);
    expect_read(addr_pccr_base, 32'hFFFF_FFFF);
    repeat (4) @(negedge clk);
    expect_read(addr_pccr_base, 32'hFFFF_FFFF);
    // stop the cycle counter, then clear all at once
    csr_write(addr_pcer, op_write, 32'h0);
    csr_write(addr_pccr_all, op_write, 32'h0);
    @(negedge clk);
    for (int i = 0; i < n_perf_cnt; i++) begin
      expect_read(csr_addr_t'(addr_pccr_base + i), '0);
    end
  endtask

  ////////////////////////////////
  // main sequence
  ////////////////////////////////

  initial begin
    lcg_state          = 32'd44717;
    rst_n              = 1'b0;
    core_id_i          = 4'h9;
    cluster_id_i       = 6'h2D;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_op_i           = op_none;
    csr_wdata_i        = '0;
    csr_save_cause_i   = 1'b0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_cause_i        = '0;
    pc_if_i            = '0;
    pc_id_i            = '0;
    id_valid_i         = 1'b0;
    is_decoding_i      = 1'b0;
    ld_stall_i         = 1'b0;
    jump_i             = 1'b0;
    branch_i           = 1'b0;
    branch_taken_i     = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_reset_values();
    test_operations();
    test_trap_return();
    test_priority();
    test_counters();
    $display("Testbench passed");
    $finish;
  end

endmodule
